/* design/hsv_core_consts.svh */
`ifndef HSV_CORE_CONSTS_SVH
`define HSV_CORE_CONSTS_SVH

// width of one architectural data word
`define HSV_XLEN 32

// architectural register count, x0 included
`define HSV_NUM_REGS 32

// index width for the register file
`define HSV_REG_ADDR_W 5

// order token carried by each issued instruction
`define HSV_TOKEN_W 4

// unit-specific control word passed through the fork
`define HSV_PAYLOAD_W 16

`endif

/* design/hsv_isa_pkg.sv */
`include "hsv_core_consts.svh"

package hsv_isa_pkg;

  // architectural register index
  typedef logic [`HSV_REG_ADDR_W-1:0] reg_addr;

  // one integer data word
  typedef logic [`HSV_XLEN-1:0] word;

  // one bit per architectural register, bit n for xn
  typedef logic [`HSV_NUM_REGS-1:0] reg_mask;

endpackage

/* design/hsv_issue_pkg.sv */
`include "hsv_core_consts.svh"

package hsv_issue_pkg;

  // target execution unit, value doubles as the fork's unit index
  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_MEM    = 2'd1,
    UNIT_BRANCH = 2'd2
  } unit_sel_e;

  // issue order, wraps around
  typedef logic [`HSV_TOKEN_W-1:0] insn_token;

  // alu view, also read by the branch unit with op as the compare kind
  typedef struct packed {
    logic [9:0] pad;
    logic       sub_arith;
    logic       use_imm;
    logic [3:0] op;
  } alu_payload_t;

  // mem view
  typedef struct packed {
    logic [11:0] pad;
    logic        sign_ext;
    logic [1:0]  size;
    logic        store;
  } mem_payload_t;

  // same control word, decoded by whichever unit receives it
  typedef union packed {
    alu_payload_t alu;
    mem_payload_t mem;
  } unit_payload_u;

endpackage

/* design/hsv_issue_scoreboard.sv */
`timescale 1ns/100ps

module hsv_issue_scoreboard (
  input  logic                 clk_core,
  input  logic                 arst_n_i,
  input  logic                 set_valid_i,
  input  hsv_isa_pkg::reg_addr set_rd_i,
  input  logic                 clr_valid_i,
  input  hsv_isa_pkg::reg_addr clr_rd_i,
  input  logic                 flush_i,
  input  hsv_isa_pkg::reg_addr rs1_i,
  input  hsv_isa_pkg::reg_addr rs2_i,
  input  hsv_isa_pkg::reg_addr rd_i,
  input  logic                 use_rs1_i,
  input  logic                 use_rs2_i,
  output logic                 hazard_o
);

  // destinations still waiting for writeback
  hsv_isa_pkg::reg_mask pending_q;
  hsv_isa_pkg::reg_mask set_mask;
  hsv_isa_pkg::reg_mask clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (set_valid_i) begin
      set_mask[set_rd_i] = 1'b1;
    end
    if (clr_valid_i) begin
      clr_mask[clr_rd_i] = 1'b1;
    end
    // x0 is never in flight
    set_mask[0] = 1'b0;
  end

  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else if (flush_i) begin
      pending_q <= '0;
    end else begin
      // set after clear, so a new issue wins over a stale writeback
      pending_q <= (pending_q & ~clr_mask) | set_mask;
    end
  end

  // rd checked too, keeps writebacks to one register in order
  assign hazard_o = (use_rs1_i & pending_q[rs1_i])
                  | (use_rs2_i & pending_q[rs2_i])
                  | pending_q[rd_i];

  // the fork only issues when hazard is low, so rd is never already pending
  a_no_double_set: assert property (
    @(posedge clk_core) disable iff (!arst_n_i)
    (set_valid_i && set_rd_i != '0) |-> !pending_q[set_rd_i]
  ) else $error("scoreboard: x%0d issued while still pending", set_rd_i);

endmodule

/* design/hsv_reg_file.sv */
`timescale 1ns/100ps

`include "hsv_core_consts.svh"

module hsv_reg_file (
  input  logic                 clk_core,
  input  logic                 arst_n_i,
  input  hsv_isa_pkg::reg_addr rd_addr_a_i,
  input  hsv_isa_pkg::reg_addr rd_addr_b_i,
  output hsv_isa_pkg::word     rd_data_a_o,
  output hsv_isa_pkg::word     rd_data_b_o,
  input  logic                 wr_en_i,
  input  hsv_isa_pkg::reg_addr wr_addr_i,
  input  hsv_isa_pkg::word     wr_data_i
);

  hsv_isa_pkg::word regs_q [`HSV_NUM_REGS];

  // one read port, with same-cycle write forwarded
  function automatic hsv_isa_pkg::word read_port(input hsv_isa_pkg::reg_addr addr);
    hsv_isa_pkg::word data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_en_i && wr_addr_i == addr) begin
      data = wr_data_i;
    end else begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `HSV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // storage and bypass both feed the ports
  always_comb begin
    rd_data_a_o = read_port(rd_addr_a_i);
    rd_data_b_o = read_port(rd_addr_b_i);
  end

  // a write aimed at x0 must not leak through the bypass
  a_x0_stays_zero: assert property (
    @(posedge clk_core) disable iff (!arst_n_i)
    (wr_en_i && wr_addr_i == '0) |->
      ((rd_addr_a_i != '0 || rd_data_a_o == '0)
       && (rd_addr_b_i != '0 || rd_data_b_o == '0))
  ) else $error("reg file: x0 read back nonzero during a write to it");

endmodule

/* design/hsv_issue_fork.sv */
`timescale 1ns/100ps

module hsv_issue_fork (
  input  logic                        clk_core,
  input  logic                        arst_n_i,
  input  logic                        valid_i,
  input  hsv_issue_pkg::unit_sel_e    unit_i,
  input  hsv_isa_pkg::word            pc_i,
  input  hsv_isa_pkg::word            imm_i,
  input  hsv_issue_pkg::unit_payload_u payload_i,
  input  hsv_isa_pkg::reg_addr        rd_i,
  input  hsv_isa_pkg::word            rs1_data_i,
  input  hsv_isa_pkg::word            rs2_data_i,
  input  logic                        hazard_i,
  input  logic                        alu_stall_i,
  input  logic                        mem_stall_i,
  input  logic                        branch_stall_i,
  input  logic                        flush_i,
  output logic                        issue_o,
  output hsv_isa_pkg::reg_addr        issue_rd_o,
  output logic                        ready_o,
  output logic                        alu_valid_o,
  output hsv_isa_pkg::word            alu_pc_o,
  output hsv_isa_pkg::word            alu_imm_o,
  output hsv_isa_pkg::word            alu_rs1_o,
  output hsv_isa_pkg::word            alu_rs2_o,
  output hsv_issue_pkg::unit_payload_u alu_payload_o,
  output hsv_issue_pkg::insn_token    alu_token_o,
  output logic                        mem_valid_o,
  output hsv_isa_pkg::word            mem_pc_o,
  output hsv_isa_pkg::word            mem_imm_o,
  output hsv_isa_pkg::word            mem_rs1_o,
  output hsv_isa_pkg::word            mem_rs2_o,
  output hsv_issue_pkg::unit_payload_u mem_payload_o,
  output hsv_issue_pkg::insn_token    mem_token_o,
  output logic                        branch_valid_o,
  output hsv_isa_pkg::word            branch_pc_o,
  output hsv_isa_pkg::word            branch_imm_o,
  output hsv_isa_pkg::word            branch_rs1_o,
  output hsv_isa_pkg::word            branch_rs2_o,
  output hsv_issue_pkg::unit_payload_u branch_payload_o,
  output hsv_issue_pkg::insn_token    branch_token_o
);

  localparam int NUM_UNITS = 3;

  // indexed by unit_sel_e value
  logic [NUM_UNITS-1:0] stall_vec;
  logic [NUM_UNITS-1:0] unit_hit;
  logic                 sel_stalled;
  logic                 accept;

  hsv_issue_pkg::insn_token token_q;

  logic [NUM_UNITS-1:0]          valid_q;
  hsv_isa_pkg::word              pc_q      [NUM_UNITS];
  hsv_isa_pkg::word              imm_q     [NUM_UNITS];
  hsv_isa_pkg::word              rs1_q     [NUM_UNITS];
  hsv_isa_pkg::word              rs2_q     [NUM_UNITS];
  hsv_issue_pkg::unit_payload_u  payload_q [NUM_UNITS];
  hsv_issue_pkg::insn_token      token_u_q [NUM_UNITS];

  assign stall_vec = {branch_stall_i, mem_stall_i, alu_stall_i};

  always_comb begin
    for (int u = 0; u < NUM_UNITS; u++) begin
      unit_hit[u] = (unit_i == hsv_issue_pkg::unit_sel_e'(u));
    end
  end

  // unknown unit codes count as stalled and never issue
  assign sel_stalled = (unit_hit == '0) || ((stall_vec & unit_hit) != '0);
  assign ready_o     = ~sel_stalled & ~hazard_i;
  // flush drops whatever is offered this cycle
  assign accept      = valid_i & ready_o & ~flush_i;

  assign issue_o    = accept;
  assign issue_rd_o = rd_i;

  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      token_q <= '0;
    end else if (flush_i) begin
      token_q <= '0;
    end else if (accept) begin
      token_q <= token_q + 1'b1;
    end
  end

  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      for (int u = 0; u < NUM_UNITS; u++) begin
        if (flush_i) begin
          valid_q[u] <= 1'b0;
        end else if (!stall_vec[u]) begin
          valid_q[u] <= accept & unit_hit[u];
        end
      end
    end
  end

  // payload side, loaded only by an accepted instruction
  always_ff @(posedge clk_core) begin
    for (int u = 0; u < NUM_UNITS; u++) begin
      if (accept && unit_hit[u]) begin
        pc_q[u]      <= pc_i;
        imm_q[u]     <= imm_i;
        rs1_q[u]     <= rs1_data_i;
        rs2_q[u]     <= rs2_data_i;
        payload_q[u] <= payload_i;
        token_u_q[u] <= token_q;
      end
    end
  end

  assign alu_valid_o   = valid_q[hsv_issue_pkg::UNIT_ALU];
  assign alu_pc_o      = pc_q[hsv_issue_pkg::UNIT_ALU];
  assign alu_imm_o     = imm_q[hsv_issue_pkg::UNIT_ALU];
  assign alu_rs1_o     = rs1_q[hsv_issue_pkg::UNIT_ALU];
  assign alu_rs2_o     = rs2_q[hsv_issue_pkg::UNIT_ALU];
  assign alu_payload_o = payload_q[hsv_issue_pkg::UNIT_ALU];
  assign alu_token_o   = token_u_q[hsv_issue_pkg::UNIT_ALU];

  assign mem_valid_o   = valid_q[hsv_issue_pkg::UNIT_MEM];
  assign mem_pc_o      = pc_q[hsv_issue_pkg::UNIT_MEM];
  assign mem_imm_o     = imm_q[hsv_issue_pkg::UNIT_MEM];
  assign mem_rs1_o     = rs1_q[hsv_issue_pkg::UNIT_MEM];
  assign mem_rs2_o     = rs2_q[hsv_issue_pkg::UNIT_MEM];
  assign mem_payload_o = payload_q[hsv_issue_pkg::UNIT_MEM];
  assign mem_token_o   = token_u_q[hsv_issue_pkg::UNIT_MEM];

  assign branch_valid_o   = valid_q[hsv_issue_pkg::UNIT_BRANCH];
  assign branch_pc_o      = pc_q[hsv_issue_pkg::UNIT_BRANCH];
  assign branch_imm_o     = imm_q[hsv_issue_pkg::UNIT_BRANCH];
  assign branch_rs1_o     = rs1_q[hsv_issue_pkg::UNIT_BRANCH];
  assign branch_rs2_o     = rs2_q[hsv_issue_pkg::UNIT_BRANCH];
  assign branch_payload_o = payload_q[hsv_issue_pkg::UNIT_BRANCH];
  assign branch_token_o   = token_u_q[hsv_issue_pkg::UNIT_BRANCH];

  // of the units free to load, one acceptance lights at most one
  a_single_target: assert property (
    @(posedge clk_core) disable iff (!arst_n_i)
    (accept && !flush_i) |=> $onehot0(valid_q & ~$past(stall_vec))
  ) else $error("fork: one acceptance raised several unit valids");

endmodule

/* design/hsv_issue_top.sv */
`timescale 1ns/100ps

module hsv_issue_top (
  input  logic                         clk_core,
  input  logic                         arst_n_i,
  input  logic                         valid_i,
  input  hsv_issue_pkg::unit_sel_e     unit_i,
  input  hsv_isa_pkg::reg_addr         rs1_i,
  input  hsv_isa_pkg::reg_addr         rs2_i,
  input  logic                         use_rs1_i,
  input  logic                         use_rs2_i,
  input  hsv_isa_pkg::reg_addr         rd_i,
  input  hsv_isa_pkg::word             pc_i,
  input  hsv_isa_pkg::word             imm_i,
  input  hsv_issue_pkg::unit_payload_u payload_i,
  input  logic                         alu_stall_i,
  input  logic                         mem_stall_i,
  input  logic                         branch_stall_i,
  input  logic                         flush_i,
  input  logic                         wb_valid_i,
  input  hsv_isa_pkg::reg_addr         wb_rd_i,
  input  hsv_isa_pkg::word             wb_data_i,
  output logic                         ready_o,
  output logic                         hazard_o,
  output logic                         alu_valid_o,
  output hsv_isa_pkg::word             alu_pc_o,
  output hsv_isa_pkg::word             alu_imm_o,
  output hsv_isa_pkg::word             alu_rs1_o,
  output hsv_isa_pkg::word             alu_rs2_o,
  output hsv_issue_pkg::unit_payload_u alu_payload_o,
  output hsv_issue_pkg::insn_token     alu_token_o,
  output logic                         mem_valid_o,
  output hsv_isa_pkg::word             mem_pc_o,
  output hsv_isa_pkg::word             mem_imm_o,
  output hsv_isa_pkg::word             mem_rs1_o,
  output hsv_isa_pkg::word             mem_rs2_o,
  output hsv_issue_pkg::unit_payload_u mem_payload_o,
  output hsv_issue_pkg::insn_token     mem_token_o,
  output logic                         branch_valid_o,
  output hsv_isa_pkg::word             branch_pc_o,
  output hsv_isa_pkg::word             branch_imm_o,
  output hsv_isa_pkg::word             branch_rs1_o,
  output hsv_isa_pkg::word             branch_rs2_o,
  output hsv_issue_pkg::unit_payload_u branch_payload_o,
  output hsv_issue_pkg::insn_token     branch_token_o
);

  logic                 issue;
  hsv_isa_pkg::reg_addr issue_rd;
  hsv_isa_pkg::word     rs1_data;
  hsv_isa_pkg::word     rs2_data;

  // set by the fork on issue, cleared by writeback
  hsv_issue_scoreboard u_scoreboard (
    .clk_core    (clk_core),
    .arst_n_i    (arst_n_i),
    .set_valid_i (issue),
    .set_rd_i    (issue_rd),
    .clr_valid_i (wb_valid_i),
    .clr_rd_i    (wb_rd_i),
    .flush_i     (flush_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rd_i        (rd_i),
    .use_rs1_i   (use_rs1_i),
    .use_rs2_i   (use_rs2_i),
    .hazard_o    (hazard_o)
  );

  hsv_reg_file u_reg_file (
    .clk_core    (clk_core),
    .arst_n_i    (arst_n_i),
    .rd_addr_a_i (rs1_i),
    .rd_addr_b_i (rs2_i),
    .rd_data_a_o (rs1_data),
    .rd_data_b_o (rs2_data),
    .wr_en_i     (wb_valid_i),
    .wr_addr_i   (wb_rd_i),
    .wr_data_i   (wb_data_i)
  );

  hsv_issue_fork u_fork (
    .clk_core         (clk_core),
    .arst_n_i         (arst_n_i),
    .valid_i          (valid_i),
    .unit_i           (unit_i),
    .pc_i             (pc_i),
    .imm_i            (imm_i),
    .payload_i        (payload_i),
    .rd_i             (rd_i),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .hazard_i         (hazard_o),
    .alu_stall_i      (alu_stall_i),
    .mem_stall_i      (mem_stall_i),
    .branch_stall_i   (branch_stall_i),
    .flush_i          (flush_i),
    .issue_o          (issue),
    .issue_rd_o       (issue_rd),
    .ready_o          (ready_o),
    .alu_valid_o      (alu_valid_o),
    .alu_pc_o         (alu_pc_o),
    .alu_imm_o        (alu_imm_o),
    .alu_rs1_o        (alu_rs1_o),
    .alu_rs2_o        (alu_rs2_o),
    .alu_payload_o    (alu_payload_o),
    .alu_token_o      (alu_token_o),
    .mem_valid_o      (mem_valid_o),
    .mem_pc_o         (mem_pc_o),
    .mem_imm_o        (mem_imm_o),
    .mem_rs1_o        (mem_rs1_o),
    .mem_rs2_o        (mem_rs2_o),
    .mem_payload_o    (mem_payload_o),
    .mem_token_o      (mem_token_o),
    .branch_valid_o   (branch_valid_o),
    .branch_pc_o      (branch_pc_o),
    .branch_imm_o     (branch_imm_o),
    .branch_rs1_o     (branch_rs1_o),
    .branch_rs2_o     (branch_rs2_o),
    .branch_payload_o (branch_payload_o),
    .branch_token_o   (branch_token_o)
  );

endmodule

/* testbench/tb_hsv_issue_vectors.svh */
`ifndef TB_HSV_ISSUE_VECTORS_SVH
`define TB_HSV_ISSUE_VECTORS_SVH

// one table row is one cycle: inputs, side levels, then expected outputs
// exp_valid is {branch, mem, alu} after the edge, chk_unit 3 means no field check
typedef struct {
  string                        name;
  logic                         valid;
  logic [1:0]                   unit;
  logic [4:0]                   rs1;
  logic                         use_rs1;
  logic [4:0]                   rs2;
  logic                         use_rs2;
  logic [4:0]                   rd;
  logic [31:0]                  pc;
  logic [31:0]                  imm;
  hsv_issue_pkg::unit_payload_u payload;
  logic                         wb_valid;
  logic [4:0]                   wb_rd;
  logic [31:0]                  wb_data;
  logic                         mem_stall;
  logic                         flush;
  logic                         wait_ready;
  logic                         exp_ready;
  logic                         exp_hazard;
  logic [2:0]                   exp_valid;
  logic [1:0]                   chk_unit;
  logic [31:0]                  exp_pc;
  logic [31:0]                  exp_imm;
  logic [31:0]                  exp_rs1;
  logic [31:0]                  exp_rs2;
  hsv_issue_pkg::unit_payload_u exp_payload;
  logic [3:0]                   exp_token;
} vec_t;

vec_t vectors[$];

function automatic hsv_issue_pkg::unit_payload_u alu_pl(input logic [3:0] op,
                                                        input logic use_imm,
                                                        input logic sub_arith);
  hsv_issue_pkg::unit_payload_u p;
  p = '0;
  p.alu.op = op;
  p.alu.use_imm = use_imm;
  p.alu.sub_arith = sub_arith;
  return p;
endfunction

function automatic hsv_issue_pkg::unit_payload_u mem_pl(input logic store,
                                                        input logic [1:0] size,
                                                        input logic sign_ext);
  hsv_issue_pkg::unit_payload_u p;
  p = '0;
  p.mem.store = store;
  p.mem.size = size;
  p.mem.sign_ext = sign_ext;
  return p;
endfunction

task automatic add_in(input string name, input logic valid, input logic [1:0] unit,
                      input logic [4:0] rs1, input logic use1, input logic [4:0] rs2,
                      input logic use2, input logic [4:0] rd, input logic [31:0] pc,
                      input logic [31:0] imm, input hsv_issue_pkg::unit_payload_u pl);
  vec_t v;
  v.name = name;
  v.valid = valid;
  v.unit = unit;
  v.rs1 = rs1;
  v.use_rs1 = use1;
  v.rs2 = rs2;
  v.use_rs2 = use2;
  v.rd = rd;
  v.pc = pc;
  v.imm = imm;
  v.payload = pl;
  vectors.push_back(v);
endtask

task automatic add_side(input logic wb_valid, input logic [4:0] wb_rd,
                        input logic [31:0] wb_data, input logic mem_stall,
                        input logic flush, input logic wait_ready);
  int last;
  last = vectors.size() - 1;
  vectors[last].wb_valid = wb_valid;
  vectors[last].wb_rd = wb_rd;
  vectors[last].wb_data = wb_data;
  vectors[last].mem_stall = mem_stall;
  vectors[last].flush = flush;
  vectors[last].wait_ready = wait_ready;
endtask

task automatic add_exp(input logic ready, input logic hazard, input logic [2:0] valids,
                       input logic [1:0] chk, input logic [31:0] pc, input logic [31:0] imm,
                       input logic [31:0] rs1, input logic [31:0] rs2,
                       input hsv_issue_pkg::unit_payload_u pl, input logic [3:0] token);
  int last;
  last = vectors.size() - 1;
  vectors[last].exp_ready = ready;
  vectors[last].exp_hazard = hazard;
  vectors[last].exp_valid = valids;
  vectors[last].chk_unit = chk;
  vectors[last].exp_pc = pc;
  vectors[last].exp_imm = imm;
  vectors[last].exp_rs1 = rs1;
  vectors[last].exp_rs2 = rs2;
  vectors[last].exp_payload = pl;
  vectors[last].exp_token = token;
endtask

// random writeback data is drawn here, so call after seeding
task automatic build_vectors();
  logic [31:0] d3;
  logic [31:0] d5;
  logic [31:0] d6;
  logic [31:0] d7;
  logic [31:0] d0;
  d3 = $urandom();
  d5 = $urandom();
  d6 = $urandom();
  d7 = $urandom();
  d0 = $urandom();
  add_in("wb_x3", 0, 0, 0, 0, 0, 0, 0, 0, 0, '0);
  add_side(1, 3, d3, 0, 0, 0);
  add_exp(1, 0, 3'b000, 3, 0, 0, 0, 0, '0, 0);
  add_in("alu_reads_x3", 1, 0, 3, 1, 0, 0, 6, 'h100, 'h10, alu_pl(3, 1, 0));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b001, 0, 'h100, 'h10, d3, 0, alu_pl(3, 1, 0), 0);
  add_in("alu_idle_drops", 0, 0, 0, 0, 0, 0, 0, 0, 0, '0);
  add_side(1, 6, d6, 0, 0, 0);
  add_exp(1, 0, 3'b000, 3, 0, 0, 0, 0, '0, 0);
  add_in("alu_writes_x5", 1, 0, 0, 0, 0, 0, 5, 'h104, 'h4, alu_pl(1, 0, 1));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b001, 0, 'h104, 'h4, 0, 0, alu_pl(1, 0, 1), 1);
  add_in("raw_x5_blocked", 1, 0, 5, 1, 0, 0, 7, 'h108, 'h8, alu_pl(2, 1, 0));
  add_side(0, 0, 0, 0, 0, 0);
  add_exp(0, 1, 3'b000, 3, 0, 0, 0, 0, '0, 0);
  add_in("raw_x5_writeback", 1, 0, 5, 1, 0, 0, 7, 'h108, 'h8, alu_pl(2, 1, 0));
  add_side(1, 5, d5, 0, 0, 0);
  add_exp(0, 1, 3'b000, 3, 0, 0, 0, 0, '0, 0);
  add_in("raw_x5_issued", 1, 0, 5, 1, 0, 0, 7, 'h108, 'h8, alu_pl(2, 1, 0));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b001, 0, 'h108, 'h8, d5, 0, alu_pl(2, 1, 0), 2);
  add_in("mem_load", 1, 1, 3, 1, 5, 1, 8, 'h10c, 'h20, mem_pl(0, 2, 1));
  add_side(1, 7, d7, 0, 0, 1);
  add_exp(1, 0, 3'b010, 1, 'h10c, 'h20, d3, d5, mem_pl(0, 2, 1), 3);
  add_in("branch_steer", 1, 2, 5, 1, 3, 1, 0, 'h110, 'h40, alu_pl(4, 0, 0));
  add_side(1, 8, d7, 0, 0, 1);
  add_exp(1, 0, 3'b100, 2, 'h110, 'h40, d5, d3, alu_pl(4, 0, 0), 4);
  add_in("mem_store", 1, 1, 3, 1, 0, 0, 9, 'h114, 'h24, mem_pl(1, 1, 0));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b010, 1, 'h114, 'h24, d3, 0, mem_pl(1, 1, 0), 5);
  add_in("mem_stall_holds", 1, 1, 0, 0, 0, 0, 10, 'h118, 'h28, mem_pl(0, 0, 0));
  add_side(0, 0, 0, 1, 0, 0);
  add_exp(0, 0, 3'b010, 1, 'h114, 'h24, d3, 0, mem_pl(1, 1, 0), 5);
  add_in("alu_past_mem_stall", 1, 0, 5, 1, 0, 0, 11, 'h11c, 'h0, alu_pl(5, 0, 0));
  add_side(0, 0, 0, 1, 0, 1);
  add_exp(1, 0, 3'b011, 0, 'h11c, 'h0, d5, 0, alu_pl(5, 0, 0), 6);
  add_in("flush_drops_all", 1, 0, 0, 0, 0, 0, 12, 'h120, 'h0, alu_pl(6, 0, 0));
  add_side(0, 0, 0, 1, 1, 0);
  add_exp(1, 0, 3'b000, 3, 0, 0, 0, 0, '0, 0);
  add_in("x9_free_after_flush", 1, 0, 9, 1, 0, 0, 13, 'h124, 'h2c, alu_pl(7, 0, 0));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b001, 0, 'h124, 'h2c, 0, 0, alu_pl(7, 0, 0), 0);
  add_in("wb_x0", 0, 0, 0, 0, 0, 0, 0, 0, 0, '0);
  add_side(1, 0, d0, 0, 0, 0);
  add_exp(1, 0, 3'b000, 3, 0, 0, 0, 0, '0, 0);
  add_in("x0_reads_zero", 1, 0, 0, 1, 0, 0, 0, 'h128, 'h30, alu_pl(8, 0, 0));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b001, 0, 'h128, 'h30, 0, 0, alu_pl(8, 0, 0), 1);
  add_in("rd_x0_no_hazard", 1, 0, 0, 1, 0, 0, 0, 'h12c, 'h34, alu_pl(9, 1, 1));
  add_side(0, 0, 0, 0, 0, 1);
  add_exp(1, 0, 3'b001, 0, 'h12c, 'h34, 0, 0, alu_pl(9, 1, 1), 2);
endtask

`endif

/* testbench/tb_hsv_issue_top.sv */
`timescale 1ns/100ps

module tb_hsv_issue_top;

  localparam int READY_TIMEOUT = 20;

  logic clk_core;
  logic arst_n_i;
  logic valid_i;
  hsv_issue_pkg::unit_sel_e unit_i;
  logic [4:0] rs1_i;
  logic [4:0] rs2_i;
  logic use_rs1_i;
  logic use_rs2_i;
  logic [4:0] rd_i;
  logic [31:0] pc_i;
  logic [31:0] imm_i;
  hsv_issue_pkg::unit_payload_u payload_i;
  logic alu_stall_i;
  logic mem_stall_i;
  logic branch_stall_i;
  logic flush_i;
  logic wb_valid_i;
  logic [4:0] wb_rd_i;
  logic [31:0] wb_data_i;
  logic ready_o;
  logic hazard_o;
  logic alu_valid_o;
  logic mem_valid_o;
  logic branch_valid_o;
  logic [31:0] alu_pc_o;
  logic [31:0] alu_imm_o;
  logic [31:0] alu_rs1_o;
  logic [31:0] alu_rs2_o;
  logic [31:0] mem_pc_o;
  logic [31:0] mem_imm_o;
  logic [31:0] mem_rs1_o;
  logic [31:0] mem_rs2_o;
  logic [31:0] branch_pc_o;
  logic [31:0] branch_imm_o;
  logic [31:0] branch_rs1_o;
  logic [31:0] branch_rs2_o;
  hsv_issue_pkg::unit_payload_u alu_payload_o;
  hsv_issue_pkg::unit_payload_u mem_payload_o;
  hsv_issue_pkg::unit_payload_u branch_payload_o;
  logic [3:0] alu_token_o;
  logic [3:0] mem_token_o;
  logic [3:0] branch_token_o;

  `include "tb_hsv_issue_vectors.svh"

  int errors;
  int tests_ok;
  int tests_bad;
  int err_before;
  int cycles;
  int seed_draw;
  vec_t v;
  logic [31:0] act_pc;
  logic [31:0] act_imm;
  logic [31:0] act_rs1;
  logic [31:0] act_rs2;
  hsv_issue_pkg::unit_payload_u act_pl;
  logic [3:0] act_tok;

  hsv_issue_top dut (.*);

  always #20 clk_core = ~clk_core;

  task automatic check_word(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic drive(input vec_t e);
    valid_i = e.valid;
    unit_i = hsv_issue_pkg::unit_sel_e'(e.unit);
    rs1_i = e.rs1;
    rs2_i = e.rs2;
    use_rs1_i = e.use_rs1;
    use_rs2_i = e.use_rs2;
    rd_i = e.rd;
    pc_i = e.pc;
    imm_i = e.imm;
    payload_i = e.payload;
    wb_valid_i = e.wb_valid;
    wb_rd_i = e.wb_rd;
    wb_data_i = e.wb_data;
    mem_stall_i = e.mem_stall;
    flush_i = e.flush;
  endtask

  task automatic read_unit(input logic [1:0] u);
    case (u)
      2'd0: begin
        act_pc = alu_pc_o;
        act_imm = alu_imm_o;
        act_rs1 = alu_rs1_o;
        act_rs2 = alu_rs2_o;
        act_pl = alu_payload_o;
        act_tok = alu_token_o;
      end
      2'd1: begin
        act_pc = mem_pc_o;
        act_imm = mem_imm_o;
        act_rs1 = mem_rs1_o;
        act_rs2 = mem_rs2_o;
        act_pl = mem_payload_o;
        act_tok = mem_token_o;
      end
      default: begin
        act_pc = branch_pc_o;
        act_imm = branch_imm_o;
        act_rs1 = branch_rs1_o;
        act_rs2 = branch_rs2_o;
        act_pl = branch_payload_o;
        act_tok = branch_token_o;
      end
    endcase
  endtask

  initial begin
    clk_core = 1'b0;
    arst_n_i = 1'b0;
    alu_stall_i = 1'b0;
    branch_stall_i = 1'b0;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    seed_draw = $urandom(5623);
    build_vectors();
    drive(vectors[2]);
    repeat (16) @(posedge clk_core);
    #2 arst_n_i = 1'b1;
    for (int i = 0; i < vectors.size(); i++) begin
      v = vectors[i];
      err_before = errors;
      drive(v);
      #28;
      if (v.wait_ready) begin
        cycles = 0;
        while (!ready_o && cycles < READY_TIMEOUT) begin
          @(posedge clk_core);
          #30;
          cycles++;
        end
        if (!ready_o) begin
          $display("%s: timed out waiting for ready", v.name);
          errors++;
        end
      end
      check_word(v.name, "ready_o", v.exp_ready, ready_o);
      check_word(v.name, "hazard_o", v.exp_hazard, hazard_o);
      @(posedge clk_core);
      #1;
      check_word(v.name, "valids", v.exp_valid, {branch_valid_o, mem_valid_o, alu_valid_o});
      if (v.chk_unit != 2'd3) begin
        read_unit(v.chk_unit);
        check_word(v.name, "pc", v.exp_pc, act_pc);
        check_word(v.name, "imm", v.exp_imm, act_imm);
        check_word(v.name, "rs1", v.exp_rs1, act_rs1);
        check_word(v.name, "rs2", v.exp_rs2, act_rs2);
        check_word(v.name, "payload", v.exp_payload, act_pl);
        check_word(v.name, "token", v.exp_token, act_tok);
        if (v.chk_unit == 2'd1) begin
          // mem fields through the mem view
          check_word(v.name, "mem view",
                     {v.exp_payload.mem.store, v.exp_payload.mem.size,
                      v.exp_payload.mem.sign_ext},
                     {act_pl.mem.store, act_pl.mem.size, act_pl.mem.sign_ext});
        end
      end
      if (errors == err_before) begin
        $display("test %s: ok", v.name);
        tests_ok++;
      end else begin
        $display("test %s: FAILED", v.name);
        tests_bad++;
      end
      #1;
    end
    $display("tests run %0d, ok %0d, failed %0d, errors %0d",
             vectors.size(), tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* hsv_issue_top.f */
+incdir+design
+incdir+testbench
design/hsv_isa_pkg.sv
design/hsv_issue_pkg.sv
design/hsv_issue_scoreboard.sv
design/hsv_reg_file.sv
design/hsv_issue_fork.sv
design/hsv_issue_top.sv
testbench/tb_hsv_issue_top.sv

/* Bender.yml */
package:
  name: hsv_issue

sources:
  - include_dirs:
      - design
    files:
      - design/hsv_isa_pkg.sv
      - design/hsv_issue_pkg.sv
      - design/hsv_issue_scoreboard.sv
      - design/hsv_reg_file.sv
      - design/hsv_issue_fork.sv
      - design/hsv_issue_top.sv
  - target: test
    include_dirs:
      - design
      - testbench
    files:
      - testbench/tb_hsv_issue_top.sv
